// ==== sources.f ====
rtl/vga_pkg.sv
rtl/raster_timer.sv
rtl/scan_buffer.sv
rtl/pixel_fetch.sv
rtl/vga_scan_top.sv
dv/clock_gen.sv
dv/vga_scan_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the scan-out simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module vga_scan_tb \
	-f sources.f \
	--Mdir obj_dir \
	-o vga_scan_sim

# a $fatal in the testbench gives a failing exit status
./obj_dir/vga_scan_sim

// ==== dv/vga_scan_tb.sv ====
// VGA scan-out testbench
`timescale 1ns/1ps

module vga_scan_tb;
	import vga_pkg::*;

	localparam int FRAME_WORDS = V_ACTIVE * H_ACTIVE / 2;
	localparam int RUN_STROBES = 3 * H_TOTAL * V_TOTAL;
	localparam int TIMEOUT_CYCLES = RUN_STROBES * PIXEL_DIV + 200;
	// first tick delay plus the startup ticks
	localparam int FIRST_STROBE = (SLOTS + 1) * PIXEL_DIV;
	localparam int H_SYNC_FROM = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_FROM = V_ACTIVE + V_FRONT;

	logic clock;
	logic reset;
	logic mem_hold = 1'b0;
	logic [PACKED_W-1:0] mem_word = '0;
	logic mem_done = 1'b0;
	logic mem_req;
	logic [ADDR_W-1:0] mem_addr;
	video_out_t video;
	logic underrun;

	// frame memory model
	logic [PACKED_W-1:0] mem_model [FRAME_WORDS];
	logic busy = 1'b0;
	int wait_left = 0;
	logic [ADDR_W-1:0] req_addr = '0;
	logic prev_hold = 1'b0;

	// raster model holds the position of the next expected strobe
	int hpos = 0;
	int vpos = 0;
	int strobes = 0;
	int cycles = 0;
	logic hold_allowed;

	clock_gen u_clock (
		.clock(clock),
		.reset(reset)
	);

	vga_scan_top DUT (
		.clock(clock),
		.reset(reset),
		.mem_hold(mem_hold),
		.mem_word(mem_word),
		.mem_done(mem_done),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.video(video),
		.underrun(underrun)
	);

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
			$display("sim failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// each 4 bit channel becomes the top nibble of an 8 bit channel
	function automatic logic [COLOR_W-1:0] expand_rgb444(input logic [11:0] rgb);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = 8'(rgb[11:8]) << 4;
		g = 8'(rgb[7:4]) << 4;
		b = 8'(rgb[3:0]) << 4;
		return {r, g, b};
	endfunction

	task automatic compare_pixel(input int h, input int v);
		logic exp_hsync;
		logic exp_vsync;
		logic visible;
		logic [PACKED_W-1:0] word;
		logic [COLOR_W-1:0] exp_color;
		exp_hsync = !((h >= H_SYNC_FROM) && (h < H_SYNC_FROM + H_SYNC));
		exp_vsync = !((v >= V_SYNC_FROM) && (v < V_SYNC_FROM + V_SYNC));
		visible = (h < H_ACTIVE) && (v < V_ACTIVE);
		exp_color = '0;
		if (visible) begin
			word = mem_model[v * (H_ACTIVE / 2) + h / 2];
			// even pixel sits in the upper half
			if (h % 2 == 0) begin
				exp_color = expand_rgb444(word[PACKED_W-1 -: 12]);
			end else begin
				exp_color = expand_rgb444(word[11:0]);
			end
		end
		check_value("hsync", int'(exp_hsync), int'(video.hsync));
		check_value("vsync", int'(exp_vsync), int'(video.vsync));
		check_value("blank_b", int'(visible), int'(video.blank_b));
		check_value("pixel colour", int'(exp_color),
			int'({video.red, video.green, video.blue}));
	endtask

	initial begin
		void'($urandom(32'hf833_662f));
		for (int i = 0; i < FRAME_WORDS; i++) begin
			mem_model[i] = PACKED_W'($urandom);
		end
	end

	//////////////////////////////
	// memory side
	//////////////////////////////

	// hold only in blank lines and released four pixels before the frame wraps
	assign hold_allowed = (vpos >= V_ACTIVE) &&
		!((vpos == V_TOTAL - 1) && (hpos >= H_TOTAL - 4));

	always @(posedge clock) begin
		if (reset) begin
			mem_hold <= 1'b0;
		end else begin
			mem_hold <= hold_allowed && ($urandom_range(2, 0) == 0);
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			mem_done <= 1'b0;
		end else if (mem_done) begin
			check_value("mem_req held up to mem_done", 1, int'(mem_req));
			mem_done <= 1'b0;
			busy <= 1'b0;
		end else if (busy) begin
			check_value("mem_req held", 1, int'(mem_req));
			check_value("mem_addr held", int'(req_addr), int'(mem_addr));
			if (wait_left == 0) begin
				mem_done <= 1'b1;
				mem_word <= mem_model[req_addr];
			end else begin
				wait_left <= wait_left - 1;
			end
		end else if (mem_req) begin
			// a new request was decided on the hold seen one edge earlier
			check_value("request address inside frame", 1,
				(int'(mem_addr) < FRAME_WORDS) ? 1 : 0);
			check_value("request started under mem_hold", 0, int'(prev_hold));
			busy <= 1'b1;
			req_addr <= mem_addr;
			wait_left <= $urandom_range(5, 0);
		end
		prev_hold <= mem_hold;
	end

	//////////////////////////////
	// video side
	//////////////////////////////

	always @(posedge clock) begin
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycles <= cycles + 1;
			check_value("underrun", 0, int'(underrun));
			// quiet output while the ring fills
			if ((strobes == 0) && !video.pixel_strobe) begin
				check_value("startup blank_b", 1, int'(video.blank_b));
				check_value("startup hsync", 1, int'(video.hsync));
				check_value("startup vsync", 1, int'(video.vsync));
				check_value("startup colour", 0,
					int'({video.red, video.green, video.blue}));
			end
			if (video.pixel_strobe) begin
				check_value("strobe cycle", FIRST_STROBE + strobes * PIXEL_DIV, cycles);
				compare_pixel(hpos, vpos);
				if (hpos == H_TOTAL - 1) begin
					hpos <= 0;
					vpos <= (vpos == V_TOTAL - 1) ? 0 : vpos + 1;
				end else begin
					hpos <= hpos + 1;
				end
				strobes <= strobes + 1;
				if (strobes == RUN_STROBES - 1) begin
					$display("sim passed");
					$finish;
				end
			end
		end
	end

endmodule

// ==== dv/clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module clock_gen (
	output logic clock,
	output logic reset
);
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 3;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// synchronous reset, released on a rising edge
	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// ==== rtl/vga_scan_top.sv ====
// VGA scan-out engine top
`timescale 1ns/1ps

module vga_scan_top (
	input logic clock,
	input logic reset,
	input logic mem_hold,
	input logic [vga_pkg::PACKED_W-1:0] mem_word,
	input logic mem_done,
	output logic mem_req,
	output logic [vga_pkg::ADDR_W-1:0] mem_addr,
	output vga_pkg::video_out_t video,
	output logic underrun
);
	import vga_pkg::*;

	logic tick;
	raster_pos_t tick_pos;
	raster_pos_t fill_pos;
	logic [SLOT_W:0] fill_count;
	logic [COLOR_W-1:0] fill_pixel;
	logic fill_we;

	// producer
	raster_timer u_timer (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.tick_pos(tick_pos)
	);

	scan_buffer u_buffer (
		.clock(clock),
		.reset(reset),
		.tick(tick),
		.tick_pos(tick_pos),
		.fill_pos(fill_pos),
		.fill_count(fill_count),
		.fill_pixel(fill_pixel),
		.fill_we(fill_we),
		.video(video),
		.underrun(underrun)
	);

	// consumer, talks to frame memory
	pixel_fetch u_fetch (
		.clock(clock),
		.reset(reset),
		.fill_pos(fill_pos),
		.fill_count(fill_count),
		.fill_pixel(fill_pixel),
		.fill_we(fill_we),
		.mem_hold(mem_hold),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_word(mem_word),
		.mem_done(mem_done)
	);

endmodule

// ==== rtl/pixel_fetch.sv ====
// Pixel fetcher
`timescale 1ns/1ps

module pixel_fetch (
	input logic clock,
	input logic reset,
	input vga_pkg::raster_pos_t fill_pos,
	input logic [vga_pkg::SLOT_W:0] fill_count,
	output logic [vga_pkg::COLOR_W-1:0] fill_pixel,
	output logic fill_we,
	input logic mem_hold,
	output logic mem_req,
	output logic [vga_pkg::ADDR_W-1:0] mem_addr,
	input logic [vga_pkg::PACKED_W-1:0] mem_word,
	input logic mem_done
);
	import vga_pkg::*;

	fetch_state_t state;
	logic [COLOR_W-1:0] odd_pixel;
	logic slot_black;
	logic start_black;
	logic start_pair;
	logic word_back;
	logic [ADDR_W-1:0] pair_addr;

	// rgb444 to 24 bit colour, low nibble of each channel zero
	function automatic logic [COLOR_W-1:0] widen(input logic [RGB444_W-1:0] rgb);
		return {rgb[11:8], 4'b0000, rgb[7:4], 4'b0000, rgb[3:0], 4'b0000};
	endfunction

	// two pixels per memory word
	assign pair_addr = ADDR_W'(fill_pos.vcount * (H_ACTIVE / 2) + fill_pos.hcount / 2);

	// odd visible slot only shows up after an underrun skip
	assign slot_black = fill_pos.blank || fill_pos.hcount[0];

	// wait while a fill is still in flight, fill_count lags by a clock
	assign start_black = (state == IDLE) && !fill_we && (fill_count != '0) && slot_black;
	assign start_pair = (state == IDLE) && !fill_we && !mem_hold &&
		(fill_count >= (SLOT_W + 1)'(2)) && !slot_black;
	assign word_back = (state == REQUEST) && mem_done;

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			mem_req <= 1'b0;
			fill_we <= 1'b0;
		end else begin
			fill_we <= 1'b0;
			case (state)
				IDLE: begin
					if (start_pair) begin
						state <= REQUEST;
						mem_req <= 1'b1;
					end else if (start_black) begin
						state <= BLACK;
						fill_we <= 1'b1;
					end
				end
				REQUEST: begin
					if (word_back) begin
						state <= FILL_SECOND;
						mem_req <= 1'b0;
						fill_we <= 1'b1;
					end
				end
				FILL_SECOND: begin
					state <= IDLE;
					fill_we <= 1'b1;
				end
				BLACK: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// address and pixel data
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (start_pair) begin
			mem_addr <= pair_addr;
		end
		if (start_black) begin
			fill_pixel <= '0;
		end
		// even pixel in the upper half
		if (word_back) begin
			fill_pixel <= widen(mem_word[PACKED_W-1 -: RGB444_W]);
			odd_pixel <= widen(mem_word[RGB444_W-1:0]);
		end
		if (state == FILL_SECOND) begin
			fill_pixel <= odd_pixel;
		end
	end

	a_req_stable: assert property (
		@(posedge clock) disable iff (reset)
		(mem_req && !mem_done) |=> (mem_req && $stable(mem_addr))
	);

endmodule

// ==== rtl/scan_buffer.sv ====
// Scan buffer ring
`timescale 1ns/1ps

module scan_buffer (
	input logic clock,
	input logic reset,
	input logic tick,
	input vga_pkg::raster_pos_t tick_pos,
	output vga_pkg::raster_pos_t fill_pos,
	output logic [vga_pkg::SLOT_W:0] fill_count,
	input logic [vga_pkg::COLOR_W-1:0] fill_pixel,
	input logic fill_we,
	output vga_pkg::video_out_t video,
	output logic underrun
);
	import vga_pkg::*;

	typedef enum logic {STARTUP, RUNNING} startup_state_t;

	// slot storage
	raster_pos_t pos_mem [SLOTS];
	logic [COLOR_W-1:0] pix_mem [SLOTS];
	logic [SLOTS-1:0] filled;

	// pointers carry one extra wrap bit
	logic [SLOT_W:0] head_ptr;
	logic [SLOT_W:0] fill_ptr;
	logic [SLOT_W-1:0] head_idx;
	logic [SLOT_W-1:0] fill_idx;

	startup_state_t state;
	logic show_now;
	logic fill_skip;
	raster_pos_t show_pos;
	logic show_filled;
	logic [COLOR_W-1:0] show_pixel;

	assign head_idx = head_ptr[SLOT_W-1:0];
	assign fill_idx = fill_ptr[SLOT_W-1:0];
	assign fill_count = head_ptr - fill_ptr;
	assign fill_pos = pos_mem[fill_idx];

	// old content of the slot about to be overwritten
	assign show_pos = pos_mem[head_idx];
	assign show_filled = filled[head_idx];
	assign show_pixel = show_filled ? pix_mem[head_idx] : '0;
	assign show_now = tick && (state == RUNNING);

	// fill slot is being displayed, move past it
	assign fill_skip = tick && (fill_count == (SLOT_W + 1)'(SLOTS));

	//////////////////////////////
	// ring storage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (fill_we) begin
			pix_mem[fill_idx] <= fill_pixel;
		end
		if (tick) begin
			pos_mem[head_idx] <= tick_pos;
		end
	end

	// a new record starts unfilled
	always_ff @(posedge clock) begin
		if (reset) begin
			filled <= '0;
		end else begin
			if (fill_we) begin
				filled[fill_idx] <= 1'b1;
			end
			if (tick) begin
				filled[head_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			fill_ptr <= '0;
		end else begin
			if (tick) begin
				head_ptr <= head_ptr + 1'b1;
			end
			if (fill_we || fill_skip) begin
				fill_ptr <= fill_ptr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// display side
	//////////////////////////////

	// output is quiet until the ring has gone round once
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= STARTUP;
		end else if (tick && (state == STARTUP) && (head_idx == SLOT_W'(SLOTS - 1))) begin
			state <= RUNNING;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			video <= VIDEO_IDLE;
		end else if (show_now) begin
			video.red <= show_pixel[COLOR_W-1 -: CHAN_W];
			video.green <= show_pixel[COLOR_W-CHAN_W-1 -: CHAN_W];
			video.blue <= show_pixel[CHAN_W-1:0];
			video.hsync <= show_pos.hsync;
			video.vsync <= show_pos.vsync;
			video.blank_b <= !show_pos.blank;
			video.pixel_strobe <= 1'b1;
		end else if (tick) begin
			video <= VIDEO_IDLE;
		end else begin
			video.pixel_strobe <= 1'b0;
		end
	end

	// sticky, an unfilled slot reached the display
	always_ff @(posedge clock) begin
		if (reset) begin
			underrun <= 1'b0;
		end else if (show_now && !show_filled) begin
			underrun <= 1'b1;
		end
	end

	a_fill_has_slot: assert property (
		@(posedge clock) disable iff (reset)
		fill_we |-> (fill_count != '0)
	);

	a_no_underrun: assert property (
		@(posedge clock) disable iff (reset)
		show_now |-> show_filled
	);

endmodule

// ==== rtl/raster_timer.sv ====
// Raster timer
`timescale 1ns/1ps

module raster_timer (
	input logic clock,
	input logic reset,
	output logic tick,
	output vga_pkg::raster_pos_t tick_pos
);
	import vga_pkg::*;

	logic [DIV_W-1:0] div_count;
	logic [HCOUNT_W-1:0] hcount;
	logic [VCOUNT_W-1:0] vcount;
	logic h_last;
	logic v_last;

	//////////////////////////////
	// pixel tick divider
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			div_count <= '0;
		end else if (tick) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	assign tick = (div_count == DIV_W'(PIXEL_DIV - 1));

	//////////////////////////////
	// position counters
	//////////////////////////////

	assign h_last = (hcount == HCOUNT_W'(H_TOTAL - 1));
	assign v_last = (vcount == VCOUNT_W'(V_TOTAL - 1));

	// counters hold the position issued on the next tick
	always_ff @(posedge clock) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (tick) begin
			if (h_last) begin
				hcount <= '0;
				vcount <= v_last ? '0 : vcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// sync and blank decoded for the current position
	always_comb begin
		tick_pos.hcount = hcount;
		tick_pos.vcount = vcount;
		tick_pos.hsync = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
		tick_pos.vsync = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));
		tick_pos.blank = (hcount >= HCOUNT_W'(H_ACTIVE)) ||
			(vcount >= VCOUNT_W'(V_ACTIVE));
	end

	// counters never leave the frame
	a_count_range: assert property (
		@(posedge clock) disable iff (reset)
		(hcount < HCOUNT_W'(H_TOTAL)) && (vcount < VCOUNT_W'(V_TOTAL))
	);

endmodule

// ==== rtl/vga_pkg.sv ====
// VGA scan-out definitions
package vga_pkg;

	//////////////////////////////
	// raster timing
	//////////////////////////////

	// horizontal, in pixels
	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_TOTAL = 24;

	// vertical, in lines
	localparam int V_ACTIVE = 6;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 10;

	// clocks per pixel tick
	localparam int PIXEL_DIV = 4;
	// ring depth, also the display delay in ticks
	localparam int SLOTS = 8;

	// widths
	localparam int HCOUNT_W = 5;
	localparam int VCOUNT_W = 4;
	localparam int ADDR_W = 6;
	localparam int COLOR_W = 24;
	localparam int PACKED_W = 24;
	localparam int RGB444_W = PACKED_W / 2;
	localparam int CHAN_W = COLOR_W / 3;
	localparam int DIV_W = $clog2(PIXEL_DIV);
	localparam int SLOT_W = $clog2(SLOTS);

	// sync windows start right after the front porch
	localparam logic [HCOUNT_W-1:0] H_SYNC_START = HCOUNT_W'(H_ACTIVE + H_FRONT);
	localparam logic [HCOUNT_W-1:0] H_SYNC_END = HCOUNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [VCOUNT_W-1:0] V_SYNC_START = VCOUNT_W'(V_ACTIVE + V_FRONT);
	localparam logic [VCOUNT_W-1:0] V_SYNC_END = VCOUNT_W'(V_ACTIVE + V_FRONT + V_SYNC);

	//////////////////////////////
	// records
	//////////////////////////////

	// one timing record per pixel tick, syncs active low
	typedef struct packed {
		logic [HCOUNT_W-1:0] hcount;
		logic [VCOUNT_W-1:0] vcount;
		logic hsync;
		logic vsync;
		logic blank;
	} raster_pos_t;

	typedef struct packed {
		logic [CHAN_W-1:0] red;
		logic [CHAN_W-1:0] green;
		logic [CHAN_W-1:0] blue;
		logic hsync;
		logic vsync;
		logic blank_b;
		logic pixel_strobe;
	} video_out_t;

	// quiet output: black, syncs and blank_b inactive, no strobe
	localparam video_out_t VIDEO_IDLE = '{
		red: 8'h00,
		green: 8'h00,
		blue: 8'h00,
		hsync: 1'b1,
		vsync: 1'b1,
		blank_b: 1'b1,
		pixel_strobe: 1'b0
	};

	typedef enum logic [1:0] {IDLE, REQUEST, FILL_SECOND, BLACK} fetch_state_t;

endpackage
